// File: source/fpu_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, unit codes and sub-op codes shared by the
// scalar FPU blocks and its testbench
// include where a macro is needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// single precision operand layout
`define FPU_EXPWIDTH    8
`define FPU_PRECISION   24
`define FPU_FLEN        (`FPU_EXPWIDTH + `FPU_PRECISION)
`define FPU_XLEN        64
`define FPU_FFLAGS_W    5

// control tag field widths
`define FPU_REGIDX_W    8
`define FPU_WARP_W      3
`define FPU_SOFT_THREAD 4

// op word is {unit code, sub-op}
`define FPU_FU_W        3
`define FPU_SUBOP_W     3
`define FPU_FU_FCMP     3'd1
`define FPU_FU_FPMV     3'd2

`define FCMP_FLE        3'd0
`define FCMP_FLT        3'd1
`define FCMP_FEQ        3'd2
`define FCMP_FMIN       3'd3
`define FCMP_FMAX       3'd4

`define FPMV_SGNJ       3'd0
`define FPMV_SGNJN      3'd1
`define FPMV_SGNJX      3'd2
`define FPMV_MV         3'd3
`define FPMV_CLASS      3'd4

`define FPU_CANON_NAN   32'h7FC0_0000
`define FFLAG_NV        4
`define FFLAG_NX        0

`endif

// File: source/fpu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types of the scalar FPU: operand words,
// op word, flags, control tag and result
// compile before any block that names fpu_pkg::
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "fpu_defines.svh"

package fpu_pkg;

  typedef struct packed {
    logic                       sign;
    logic [`FPU_EXPWIDTH-1:0]   exp;
    logic [`FPU_PRECISION-2:0]  frac;
  } fp32_fields_t;

  // compare and classify read the fields, moves read the raw word
  typedef union packed {
    fp32_fields_t               f;
    logic [`FPU_FLEN-1:0]       raw;
  } fp_word_u;

  typedef struct packed {
    logic [`FPU_FU_W-1:0]       fu;
    logic [`FPU_SUBOP_W-1:0]    subop;
  } fpu_op_t;

  typedef logic [`FPU_FFLAGS_W-1:0] fflags_t;

  // carried through each unit untouched
  typedef struct packed {
    logic [`FPU_REGIDX_W-1:0]    regindex;
    logic [`FPU_WARP_W-1:0]      warpid;
    logic [`FPU_SOFT_THREAD-1:0] vecmask;
    logic                        wvd;
    logic                        wxd;
  } ctrl_tag_t;

  typedef logic [`FPU_XLEN-1:0] fpu_result_t;

endpackage

`default_nettype wire

// File: source/fpu_dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// input side of the scalar FPU: decodes the unit
// code, raises the addressed unit's valid and
// returns that unit's ready; purely combinational
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "fpu_defines.svh"

module fpu_dispatch (
  input  wire  fpu_pkg::fpu_op_t    op_i,
  input  wire  fpu_pkg::fp_word_u   a_i,
  input  wire  fpu_pkg::fp_word_u   b_i,
  input  wire  fpu_pkg::ctrl_tag_t  tag_i,
  input  wire                       in_valid_i,
  output logic                      in_ready_o,
  output logic                      fcmp_valid_o,
  input  wire                       fcmp_ready_i,
  output logic                      fpmv_valid_o,
  input  wire                       fpmv_ready_i,
  output logic [`FPU_SUBOP_W-1:0]   unit_subop_o,
  output fpu_pkg::fp_word_u         unit_a_o,
  output fpu_pkg::fp_word_u         unit_b_o,
  output fpu_pkg::ctrl_tag_t        unit_tag_o
);

  logic hit_fcmp;
  logic hit_fpmv;
  logic hit_any;

  assign hit_fcmp = (op_i.fu == `FPU_FU_FCMP);
  assign hit_fpmv = (op_i.fu == `FPU_FU_FPMV);
  assign hit_any  = hit_fcmp | hit_fpmv;

  assign fcmp_valid_o = in_valid_i & hit_fcmp;
  assign fpmv_valid_o = in_valid_i & hit_fpmv;

  // shared payload lines, zero for codes no unit serves
  assign unit_subop_o = hit_any ? op_i.subop : '0;
  assign unit_a_o     = hit_any ? a_i : '0;
  assign unit_b_o     = hit_any ? b_i : '0;
  assign unit_tag_o   = hit_any ? tag_i : '0;

  // ready of the unit the incoming op addresses
  assign in_ready_o = hit_fcmp ? fcmp_ready_i :
                      hit_fpmv ? fpmv_ready_i : 1'b0;

endmodule

`default_nettype wire

// File: source/fcmp_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single precision compare unit: fle, flt, feq,
// fmin and fmax with invalid-operation flags
// one output register, one cycle of latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "fpu_defines.svh"

module fcmp_unit (
  input  wire                       clk,
  input  wire                       rst_n_i,
  input  wire                       in_valid_i,
  output logic                      in_ready_o,
  input  wire  [`FPU_SUBOP_W-1:0]   subop_i,
  input  wire  fpu_pkg::fp_word_u   a_i,
  input  wire  fpu_pkg::fp_word_u   b_i,
  input  wire  fpu_pkg::ctrl_tag_t  tag_i,
  output logic                      out_valid_o,
  input  wire                       out_ready_i,
  output fpu_pkg::fpu_result_t      result_o,
  output fpu_pkg::fflags_t          fflags_o,
  output fpu_pkg::ctrl_tag_t        tag_o
);

  logic                 a_nan;
  logic                 b_nan;
  logic                 any_nan;
  logic                 any_snan;
  logic                 both_zero;
  logic                 mag_lt;
  logic                 mag_eq;
  logic                 ord_lt;
  logic                 lt;
  logic                 eq;
  logic [`FPU_FLEN-1:0] minmax;
  fpu_pkg::fpu_result_t result_d;
  fpu_pkg::fflags_t     fflags_d;

  assign a_nan    = (a_i.f.exp == '1) && (a_i.f.frac != '0);
  assign b_nan    = (b_i.f.exp == '1) && (b_i.f.frac != '0);
  assign any_nan  = a_nan | b_nan;
  // quiet bit clear marks a signaling NaN
  assign any_snan = (a_nan && !a_i.f.frac[`FPU_PRECISION-2]) ||
                    (b_nan && !b_i.f.frac[`FPU_PRECISION-2]);

  assign both_zero = ({a_i.f.exp, a_i.f.frac} == '0) && ({b_i.f.exp, b_i.f.frac} == '0);
  assign mag_lt    = {a_i.f.exp, a_i.f.frac} < {b_i.f.exp, b_i.f.frac};
  assign mag_eq    = {a_i.f.exp, a_i.f.frac} == {b_i.f.exp, b_i.f.frac};

  // total order with -0 below +0
  assign ord_lt = (a_i.f.sign != b_i.f.sign) ? a_i.f.sign :
                  (a_i.f.sign ? !(mag_lt || mag_eq) : mag_lt);

  // ieee order, signed zeros equal
  assign lt = !any_nan && !both_zero && ord_lt;
  assign eq = !any_nan && (both_zero || (a_i.f.sign == b_i.f.sign && mag_eq));

  always_comb begin
    if (a_nan && b_nan) begin
      minmax = `FPU_CANON_NAN;
    end else if (a_nan) begin
      minmax = b_i.raw;
    end else if (b_nan) begin
      minmax = a_i.raw;
    end else if (ord_lt ^ (subop_i == `FCMP_FMAX)) begin
      minmax = a_i.raw;
    end else begin
      minmax = b_i.raw;
    end
  end

  always_comb begin
    result_d = '0;
    fflags_d = '0;
    case (subop_i)
      `FCMP_FLE: begin
        result_d[0]         = lt | eq;
        fflags_d[`FFLAG_NV] = any_nan;
      end
      `FCMP_FLT: begin
        result_d[0]         = lt;
        fflags_d[`FFLAG_NV] = any_nan;
      end
      `FCMP_FEQ: begin
        result_d[0]         = eq;
        fflags_d[`FFLAG_NV] = any_snan;
      end
      `FCMP_FMIN, `FCMP_FMAX: begin
        result_d[`FPU_FLEN-1:0] = minmax;
        fflags_d[`FFLAG_NV]     = any_snan;
      end
      default: begin
        result_d = '0;
      end
    endcase
  end

  // register is free when empty or draining this cycle
  assign in_ready_o = !out_valid_o || out_ready_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      result_o <= result_d;
      fflags_o <= fflags_d;
      tag_o    <= tag_i;
    end
  end

endmodule

`default_nettype wire

// File: source/fpmv_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sign injection, raw move and fclass unit
// never raises a flag; one output register,
// one cycle of latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "fpu_defines.svh"

module fpmv_unit (
  input  wire                       clk,
  input  wire                       rst_n_i,
  input  wire                       in_valid_i,
  output logic                      in_ready_o,
  input  wire  [`FPU_SUBOP_W-1:0]   subop_i,
  input  wire  fpu_pkg::fp_word_u   a_i,
  input  wire  fpu_pkg::fp_word_u   b_i,
  input  wire  fpu_pkg::ctrl_tag_t  tag_i,
  output logic                      out_valid_o,
  input  wire                       out_ready_i,
  output fpu_pkg::fpu_result_t      result_o,
  output fpu_pkg::fflags_t          fflags_o,
  output fpu_pkg::ctrl_tag_t        tag_o
);

  logic                   exp_ones;
  logic                   exp_zero;
  logic                   frac_zero;
  logic                   is_nan;
  logic                   quiet;
  logic                   sgn;
  logic [9:0]             class_mask;
  logic [`FPU_FLEN-2:0]   a_mag;
  fpu_pkg::fpu_result_t   result_d;

  assign exp_ones  = (a_i.f.exp == '1);
  assign exp_zero  = (a_i.f.exp == '0);
  assign frac_zero = (a_i.f.frac == '0);
  assign is_nan    = exp_ones && !frac_zero;
  assign quiet     = a_i.f.frac[`FPU_PRECISION-2];
  assign sgn       = a_i.f.sign;

  // risc-v fclass bits, -inf in bit 0 up to qnan in bit 9
  assign class_mask = {is_nan && quiet,
                       is_nan && !quiet,
                       !sgn && exp_ones && frac_zero,
                       !sgn && !exp_ones && !exp_zero,
                       !sgn && exp_zero && !frac_zero,
                       !sgn && exp_zero && frac_zero,
                       sgn && exp_zero && frac_zero,
                       sgn && exp_zero && !frac_zero,
                       sgn && !exp_ones && !exp_zero,
                       sgn && exp_ones && frac_zero};

  assign a_mag = a_i.raw[`FPU_FLEN-2:0];

  always_comb begin
    result_d = '0;
    case (subop_i)
      `FPMV_SGNJ:  result_d[`FPU_FLEN-1:0] = {b_i.f.sign, a_mag};
      `FPMV_SGNJN: result_d[`FPU_FLEN-1:0] = {~b_i.f.sign, a_mag};
      `FPMV_SGNJX: result_d[`FPU_FLEN-1:0] = {a_i.f.sign ^ b_i.f.sign, a_mag};
      `FPMV_MV:    result_d[`FPU_FLEN-1:0] = a_i.raw;
      `FPMV_CLASS: result_d[9:0]           = class_mask;
      default:     result_d                = '0;
    endcase
  end

  assign in_ready_o = !out_valid_o || out_ready_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  // flags stay zero for every move op
  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      result_o <= result_d;
      fflags_o <= '0;
      tag_o    <= tag_i;
    end
  end

endmodule

`default_nettype wire

// File: source/fpu_result_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output side of the scalar FPU: fixed priority
// grant (compare before move), binary select,
// result mux and out_ready to the granted unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "fpu_defines.svh"

module fpu_result_arbiter (
  input  wire                         fcmp_valid_i,
  input  wire                         fpmv_valid_i,
  output logic                        fcmp_ready_o,
  output logic                        fpmv_ready_o,
  input  wire  fpu_pkg::fpu_result_t  fcmp_result_i,
  input  wire  fpu_pkg::fpu_result_t  fpmv_result_i,
  input  wire  fpu_pkg::fflags_t      fcmp_fflags_i,
  input  wire  fpu_pkg::fflags_t      fpmv_fflags_i,
  input  wire  fpu_pkg::ctrl_tag_t    fcmp_tag_i,
  input  wire  fpu_pkg::ctrl_tag_t    fpmv_tag_i,
  input  wire                         out_ready_i,
  output logic                        out_valid_o,
  output logic [`FPU_FU_W-1:0]        select_o,
  output fpu_pkg::fpu_result_t        result_o,
  output fpu_pkg::fflags_t            fflags_o,
  output fpu_pkg::ctrl_tag_t          tag_o
);

  logic grant_fcmp;
  logic grant_fpmv;

  assign grant_fcmp  = fcmp_valid_i;
  assign grant_fpmv  = fpmv_valid_i && !fcmp_valid_i;
  assign out_valid_o = fcmp_valid_i | fpmv_valid_i;

  // select carries the granted unit's code, 0 when idle
  assign select_o = grant_fcmp ? `FPU_FU_FCMP :
                    grant_fpmv ? `FPU_FU_FPMV : '0;

  // a waiting unit keeps its result until granted
  assign fcmp_ready_o = grant_fcmp & out_ready_i;
  assign fpmv_ready_o = grant_fpmv & out_ready_i;

  always_comb begin
    if (grant_fcmp) begin
      result_o = fcmp_result_i;
      fflags_o = fcmp_fflags_i;
      tag_o    = fcmp_tag_i;
    end else if (grant_fpmv) begin
      result_o = fpmv_result_i;
      fflags_o = fpmv_fflags_i;
      tag_o    = fpmv_tag_i;
    end else begin
      result_o = '0;
      fflags_o = '0;
      tag_o    = '0;
    end
  end

endmodule

`default_nettype wire

// File: source/scalar_fpu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scalar single precision FPU with compare and
// sign/move units behind one valid/ready port
// op_i = {unit code, sub-op}; results may return
// out of order, the control tag tells them apart
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "fpu_defines.svh"

module scalar_fpu (
  input  wire                          clk,
  input  wire                          rst_n_i,
  input  wire  fpu_pkg::fpu_op_t       op_i,
  input  wire  fpu_pkg::fp_word_u      a_i,
  input  wire  fpu_pkg::fp_word_u      b_i,
  input  wire  [`FPU_REGIDX_W-1:0]     ctrl_regindex_i,
  input  wire  [`FPU_WARP_W-1:0]       ctrl_warpid_i,
  input  wire  [`FPU_SOFT_THREAD-1:0]  ctrl_vecmask_i,
  input  wire                          ctrl_wvd_i,
  input  wire                          ctrl_wxd_i,
  input  wire                          in_valid_i,
  input  wire                          out_ready_i,
  output logic                         in_ready_o,
  output logic                         out_valid_o,
  output logic [`FPU_FU_W-1:0]         select_o,
  output fpu_pkg::fpu_result_t         result_o,
  output fpu_pkg::fflags_t             fflags_o,
  output logic [`FPU_REGIDX_W-1:0]     ctrl_regindex_o,
  output logic [`FPU_WARP_W-1:0]       ctrl_warpid_o,
  output logic [`FPU_SOFT_THREAD-1:0]  ctrl_vecmask_o,
  output logic                         ctrl_wvd_o,
  output logic                         ctrl_wxd_o
);

  fpu_pkg::ctrl_tag_t      in_tag;
  fpu_pkg::ctrl_tag_t      out_tag;
  fpu_pkg::ctrl_tag_t      unit_tag;
  logic [`FPU_SUBOP_W-1:0] unit_subop;
  fpu_pkg::fp_word_u       unit_a;
  fpu_pkg::fp_word_u       unit_b;

  logic                    fcmp_in_valid;
  logic                    fcmp_in_ready;
  logic                    fcmp_out_valid;
  logic                    fcmp_out_ready;
  fpu_pkg::fpu_result_t    fcmp_result;
  fpu_pkg::fflags_t        fcmp_fflags;
  fpu_pkg::ctrl_tag_t      fcmp_tag;

  logic                    fpmv_in_valid;
  logic                    fpmv_in_ready;
  logic                    fpmv_out_valid;
  logic                    fpmv_out_ready;
  fpu_pkg::fpu_result_t    fpmv_result;
  fpu_pkg::fflags_t        fpmv_fflags;
  fpu_pkg::ctrl_tag_t      fpmv_tag;

  assign in_tag = '{regindex: ctrl_regindex_i, warpid: ctrl_warpid_i,
                    vecmask: ctrl_vecmask_i, wvd: ctrl_wvd_i, wxd: ctrl_wxd_i};

  assign ctrl_regindex_o = out_tag.regindex;
  assign ctrl_warpid_o   = out_tag.warpid;
  assign ctrl_vecmask_o  = out_tag.vecmask;
  assign ctrl_wvd_o      = out_tag.wvd;
  assign ctrl_wxd_o      = out_tag.wxd;

  fpu_dispatch u_dispatch (
    .op_i         (op_i),
    .a_i          (a_i),
    .b_i          (b_i),
    .tag_i        (in_tag),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .fcmp_valid_o (fcmp_in_valid),
    .fcmp_ready_i (fcmp_in_ready),
    .fpmv_valid_o (fpmv_in_valid),
    .fpmv_ready_i (fpmv_in_ready),
    .unit_subop_o (unit_subop),
    .unit_a_o     (unit_a),
    .unit_b_o     (unit_b),
    .unit_tag_o   (unit_tag)
  );

  fcmp_unit u_fcmp (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (fcmp_in_valid),
    .in_ready_o  (fcmp_in_ready),
    .subop_i     (unit_subop),
    .a_i         (unit_a),
    .b_i         (unit_b),
    .tag_i       (unit_tag),
    .out_valid_o (fcmp_out_valid),
    .out_ready_i (fcmp_out_ready),
    .result_o    (fcmp_result),
    .fflags_o    (fcmp_fflags),
    .tag_o       (fcmp_tag)
  );

  fpmv_unit u_fpmv (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (fpmv_in_valid),
    .in_ready_o  (fpmv_in_ready),
    .subop_i     (unit_subop),
    .a_i         (unit_a),
    .b_i         (unit_b),
    .tag_i       (unit_tag),
    .out_valid_o (fpmv_out_valid),
    .out_ready_i (fpmv_out_ready),
    .result_o    (fpmv_result),
    .fflags_o    (fpmv_fflags),
    .tag_o       (fpmv_tag)
  );

  fpu_result_arbiter u_arbiter (
    .fcmp_valid_i  (fcmp_out_valid),
    .fpmv_valid_i  (fpmv_out_valid),
    .fcmp_ready_o  (fcmp_out_ready),
    .fpmv_ready_o  (fpmv_out_ready),
    .fcmp_result_i (fcmp_result),
    .fpmv_result_i (fpmv_result),
    .fcmp_fflags_i (fcmp_fflags),
    .fpmv_fflags_i (fpmv_fflags),
    .fcmp_tag_i    (fcmp_tag),
    .fpmv_tag_i    (fpmv_tag),
    .out_ready_i   (out_ready_i),
    .out_valid_o   (out_valid_o),
    .select_o      (select_o),
    .result_o      (result_o),
    .fflags_o      (fflags_o),
    .tag_o         (out_tag)
  );

endmodule

`default_nettype wire

// File: dv/scalar_fpu_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent checks on the scalar FPU top-level
// handshake, bound into every scalar_fpu instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "fpu_defines.svh"

module scalar_fpu_sva (
  input wire                        clk,
  input wire                        rst_n_i,
  input wire  [`FPU_FU_W-1:0]       fu_i,
  input wire                        in_ready_i,
  input wire                        out_valid_i,
  input wire                        out_ready_i,
  input wire  [`FPU_FU_W-1:0]       select_i,
  input wire  fpu_pkg::fpu_result_t result_i
);

  // read by the testbench to stop the run
  int assert_failures = 0;

  // a compare result arriving may take the grant from a waiting move result
  hold_output: assert property (@(posedge clk) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i |=>
      out_valid_i && ($stable(select_i) ? $stable(result_i) : select_i == `FPU_FU_FCMP))
    else begin
      assert_failures++;
      $error("output dropped or changed while out_ready was low");
    end

  unsupported_not_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
    (fu_i != `FPU_FU_FCMP) && (fu_i != `FPU_FU_FPMV) |-> !in_ready_i)
    else begin
      assert_failures++;
      $error("in_ready high for an unsupported unit code");
    end

  idle_after_reset: assert property (@(posedge clk) !rst_n_i |=> !out_valid_i)
    else begin
      assert_failures++;
      $error("out_valid high in the cycle after reset");
    end

endmodule

bind scalar_fpu scalar_fpu_sva u_sva (
  .clk         (clk),
  .rst_n_i     (rst_n_i),
  .fu_i        (op_i.fu),
  .in_ready_i  (in_ready_o),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .select_i    (select_o),
  .result_i    (result_o)
);

`default_nettype wire

// File: dv/tb_scalar_fpu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the scalar FPU: random and special
// operands, random output stalls, one forced stall
// phase, per-unit scoreboard queues and a watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none
`include "fpu_defines.svh"

module tb_scalar_fpu;

  localparam int CLK_PERIOD      = 8;
  localparam int N_RANDOM        = 400;
  localparam int N_OPS           = N_RANDOM + 2;
  localparam int WATCHDOG_CYCLES = N_OPS * 20 + 200;

  typedef struct packed {
    fpu_pkg::fpu_result_t res;
    fpu_pkg::fflags_t     flags;
    fpu_pkg::ctrl_tag_t   tag;
  } exp_entry_t;

  logic                         clk;
  logic                         rst_n_i;
  fpu_pkg::fpu_op_t             op_i;
  fpu_pkg::fp_word_u            a_i;
  fpu_pkg::fp_word_u            b_i;
  logic [`FPU_REGIDX_W-1:0]     ctrl_regindex_i;
  logic [`FPU_WARP_W-1:0]       ctrl_warpid_i;
  logic [`FPU_SOFT_THREAD-1:0]  ctrl_vecmask_i;
  logic                         ctrl_wvd_i;
  logic                         ctrl_wxd_i;
  logic                         in_valid_i;
  logic                         out_ready_i;
  logic                         in_ready_o;
  logic                         out_valid_o;
  logic [`FPU_FU_W-1:0]         select_o;
  fpu_pkg::fpu_result_t         result_o;
  fpu_pkg::fflags_t             fflags_o;
  logic [`FPU_REGIDX_W-1:0]     ctrl_regindex_o;
  logic [`FPU_WARP_W-1:0]       ctrl_warpid_o;
  logic [`FPU_SOFT_THREAD-1:0]  ctrl_vecmask_o;
  logic                         ctrl_wvd_o;
  logic                         ctrl_wxd_o;

  exp_entry_t fcmp_q[$];
  exp_entry_t fpmv_q[$];
  integer     seed           = 32'hf3b7;
  integer     stall_seed     = 32'hf3b7 ^ 32'h0000_5a5a;
  int         errors         = 0;
  int         both_held      = 0;
  logic       hold_ready_low = 1'b0;

  scalar_fpu i_dut (
    .clk(clk), .rst_n_i(rst_n_i), .op_i(op_i), .a_i(a_i), .b_i(b_i),
    .ctrl_regindex_i(ctrl_regindex_i), .ctrl_warpid_i(ctrl_warpid_i),
    .ctrl_vecmask_i(ctrl_vecmask_i), .ctrl_wvd_i(ctrl_wvd_i), .ctrl_wxd_i(ctrl_wxd_i),
    .in_valid_i(in_valid_i), .out_ready_i(out_ready_i), .in_ready_o(in_ready_o),
    .out_valid_o(out_valid_o), .select_o(select_o), .result_o(result_o),
    .fflags_o(fflags_o), .ctrl_regindex_o(ctrl_regindex_o), .ctrl_warpid_o(ctrl_warpid_o),
    .ctrl_vecmask_o(ctrl_vecmask_o), .ctrl_wvd_o(ctrl_wvd_o), .ctrl_wxd_o(ctrl_wxd_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the run was still busy after %0d cycles", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic stop_on_error(input string msg);
    errors++;
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_result(input fpu_pkg::fpu_result_t got, input fpu_pkg::fpu_result_t exp);
    if (got !== exp) stop_on_error($sformatf("result got %h expected %h", got, exp));
  endtask

  task automatic check_fflags(input fpu_pkg::fflags_t got, input fpu_pkg::fflags_t exp);
    if (got !== exp) stop_on_error($sformatf("fflags got %b expected %b", got, exp));
  endtask

  task automatic check_tag(input fpu_pkg::ctrl_tag_t got, input fpu_pkg::ctrl_tag_t exp);
    if (got !== exp) stop_on_error($sformatf("ctrl tag got %h expected %h", got, exp));
  endtask

  task automatic check_select(input logic [`FPU_FU_W-1:0] got, input logic [`FPU_FU_W-1:0] exp);
    if (got !== exp) stop_on_error($sformatf("select got %0d expected %0d", got, exp));
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) stop_on_error($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  // RISC-V fclass bit of a single precision word
  function automatic int class_index(input fpu_pkg::fp_word_u a);
    if (a.f.exp == 8'hff && a.f.frac != 0) return a.f.frac[22] ? 9 : 8;
    if (a.f.exp == 8'hff) return a.f.sign ? 0 : 7;
    if (a.f.exp == 0 && a.f.frac == 0) return a.f.sign ? 3 : 4;
    if (a.f.exp == 0) return a.f.sign ? 2 : 5;
    return a.f.sign ? 1 : 6;
  endfunction

  function automatic fpu_pkg::fpu_result_t ref_fpu(input fpu_pkg::fpu_op_t op,
      input fpu_pkg::fp_word_u a, input fpu_pkg::fp_word_u b, output fpu_pkg::fflags_t flags);
    logic                 a_nan;
    logic                 b_nan;
    logic                 any_snan;
    logic                 eq;
    logic                 lt;
    logic [31:0]          ka;
    logic [31:0]          kb;
    fpu_pkg::fpu_result_t res;
    a_nan    = (a.raw[30:23] == 8'hff) && (a.raw[22:0] != 0);
    b_nan    = (b.raw[30:23] == 8'hff) && (b.raw[22:0] != 0);
    any_snan = (a_nan && !a.raw[22]) || (b_nan && !b.raw[22]);
    // ordering keys: unsigned compare of keys follows the real order
    ka = a.raw[31] ? ~a.raw : (a.raw | 32'h8000_0000);
    kb = b.raw[31] ? ~b.raw : (b.raw | 32'h8000_0000);
    eq = !a_nan && !b_nan &&
         ((a.raw == b.raw) || (a.raw[30:0] == 0 && b.raw[30:0] == 0));
    lt = !a_nan && !b_nan && !eq && (ka < kb);
    res   = '0;
    flags = '0;
    if (op.fu == `FPU_FU_FCMP) begin
      case (op.subop)
        `FCMP_FLE: begin
          res[0] = lt || eq;
          flags[`FFLAG_NV] = a_nan || b_nan;
        end
        `FCMP_FLT: begin
          res[0] = lt;
          flags[`FFLAG_NV] = a_nan || b_nan;
        end
        `FCMP_FEQ: begin
          res[0] = eq;
          flags[`FFLAG_NV] = any_snan;
        end
        `FCMP_FMIN, `FCMP_FMAX: begin
          if (a_nan && b_nan) res[31:0] = `FPU_CANON_NAN;
          else if (a_nan) res[31:0] = b.raw;
          else if (b_nan) res[31:0] = a.raw;
          else if (op.subop == `FCMP_FMIN) res[31:0] = (ka < kb) ? a.raw : b.raw;
          else res[31:0] = (ka > kb) ? a.raw : b.raw;
          flags[`FFLAG_NV] = any_snan;
        end
        default: res = '0;
      endcase
    end else if (op.fu == `FPU_FU_FPMV) begin
      case (op.subop)
        `FPMV_SGNJ:  res[31:0] = {b.raw[31], a.raw[30:0]};
        `FPMV_SGNJN: res[31:0] = {!b.raw[31], a.raw[30:0]};
        `FPMV_SGNJX: res[31:0] = {a.raw[31] ^ b.raw[31], a.raw[30:0]};
        `FPMV_MV:    res[31:0] = a.raw;
        `FPMV_CLASS: res[class_index(a)] = 1'b1;
        default:     res = '0;
      endcase
    end
    return res;
  endfunction

  // zeros, infinities, NaNs of both kinds, subnormals and ordinary values
  function automatic logic [31:0] special_word(input logic [3:0] idx);
    case (idx)
      4'd0:    return 32'h0000_0000;
      4'd1:    return 32'h8000_0000;
      4'd2:    return 32'h7F80_0000;
      4'd3:    return 32'hFF80_0000;
      4'd4:    return 32'h7FC0_0000;
      4'd5:    return 32'hFFC1_2345;
      4'd6:    return 32'h7F80_0001;
      4'd7:    return 32'hFFA0_0000;
      4'd8:    return 32'h0000_0001;
      4'd9:    return 32'h807F_FFFF;
      4'd10:   return 32'h3F80_0000;
      4'd11:   return 32'hBF80_0000;
      4'd12:   return 32'h7F7F_FFFF;
      4'd13:   return 32'h0080_0000;
      4'd14:   return 32'h7FFF_FFFF;
      default: return 32'h4049_0FDB;
    endcase
  endfunction

  function automatic logic [31:0] pick_operand();
    integer r;
    r = $random(seed);
    if (r[1:0] == 2'b00) return special_word(r[7:4]);
    return $random(seed);
  endfunction

  task automatic send_op(input fpu_pkg::fpu_op_t op, input logic [31:0] a,
                         input logic [31:0] b, input logic [15:0] tag_bits);
    fpu_pkg::ctrl_tag_t tag;
    tag = tag_bits;
    @(negedge clk);
    op_i            = op;
    a_i             = a;
    b_i             = b;
    ctrl_regindex_i = tag.regindex;
    ctrl_warpid_i   = tag.warpid;
    ctrl_vecmask_i  = tag.vecmask;
    ctrl_wvd_i      = tag.wvd;
    ctrl_wxd_i      = tag.wxd;
    in_valid_i      = 1'b1;
    if (op.fu == `FPU_FU_FCMP || op.fu == `FPU_FU_FPMV) begin
      do @(posedge clk); while (!in_ready_o);
    end else begin
      // no unit takes it, so it is withdrawn
      repeat (3) @(posedge clk);
    end
  endtask

  task automatic idle_cycles(input int n);
    @(negedge clk);
    in_valid_i = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  task automatic drain_all();
    while (fcmp_q.size() != 0 || fpmv_q.size() != 0) @(negedge clk);
  endtask

  task automatic send_random_op();
    integer           r;
    integer           r_tag;
    fpu_pkg::fpu_op_t op;
    logic [31:0]      a;
    logic [31:0]      b;
    r     = $random(seed);
    r_tag = $random(seed);
    if (r[3:0] < 4'd7) op.fu = `FPU_FU_FCMP;
    else if (r[3:0] < 4'd14) op.fu = `FPU_FU_FPMV;
    else op.fu = (r[6:4] == 3'd1 || r[6:4] == 3'd2) ? 3'd0 : r[6:4];
    op.subop = r[8] ? r[11:9] : 3'(r[11:9] % 3'd5);
    a = pick_operand();
    b = pick_operand();
    if (r[13:12] == 2'b00) b = a;
    send_op(op, a, b, r_tag[15:0]);
    if (r[15:14] == 2'b00) idle_cycles(r[17:16]);
  endtask

  initial begin : ready_drive
    integer r;
    out_ready_i = 1'b0;
    forever begin
      @(negedge clk);
      r = $random(stall_seed);
      out_ready_i = hold_ready_low ? 1'b0 : (r[1:0] != 2'b00);
    end
  end

  // expected select and readiness follow from which queues hold entries
  always @(posedge clk) begin : scoreboard
    exp_entry_t           e;
    fpu_pkg::fflags_t     f;
    logic [`FPU_FU_W-1:0] exp_sel;
    logic                 exp_ready;
    if (rst_n_i) begin
      if (i_dut.u_sva.assert_failures != 0) stop_on_error("an assertion in scalar_fpu_sva failed");
      exp_sel = (fcmp_q.size() != 0) ? `FPU_FU_FCMP :
                (fpmv_q.size() != 0) ? `FPU_FU_FPMV : 3'd0;
      check_select(select_o, exp_sel);
      check_bit(out_valid_o, exp_sel != 3'd0, "out_valid");
      if (op_i.fu == `FPU_FU_FCMP || op_i.fu == `FPU_FU_FPMV) begin
        exp_ready = ((op_i.fu == `FPU_FU_FCMP) ? fcmp_q.size() == 0 : fpmv_q.size() == 0) ||
                    (exp_sel == op_i.fu && out_ready_i);
      end else begin
        exp_ready = 1'b0;
      end
      check_bit(in_ready_o, exp_ready, "in_ready");
      if (fcmp_q.size() != 0 && fpmv_q.size() != 0) both_held++;
      if (out_valid_o && out_ready_i) begin
        e = (select_o == `FPU_FU_FCMP) ? fcmp_q.pop_front() : fpmv_q.pop_front();
        check_result(result_o, e.res);
        check_fflags(fflags_o, e.flags);
        check_tag({ctrl_regindex_o, ctrl_warpid_o, ctrl_vecmask_o, ctrl_wvd_o, ctrl_wxd_o},
                  e.tag);
      end
      if (in_valid_i && in_ready_o) begin
        e.res   = ref_fpu(op_i, a_i, b_i, f);
        e.flags = f;
        e.tag   = {ctrl_regindex_i, ctrl_warpid_i, ctrl_vecmask_i, ctrl_wvd_i, ctrl_wxd_i};
        if (op_i.fu == `FPU_FU_FCMP) fcmp_q.push_back(e);
        else if (op_i.fu == `FPU_FU_FPMV) fpmv_q.push_back(e);
        else stop_on_error("an op with an unsupported unit code was accepted");
      end
    end
  end

  initial begin : main
    fpu_pkg::fpu_op_t op;
    rst_n_i         = 1'b0;
    op_i            = '0;
    a_i             = '0;
    b_i             = '0;
    ctrl_regindex_i = '0;
    ctrl_warpid_i   = '0;
    ctrl_vecmask_i  = '0;
    ctrl_wvd_i      = 1'b0;
    ctrl_wxd_i      = 1'b0;
    in_valid_i      = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    repeat (3) @(negedge clk);

    for (int i = 0; i < N_RANDOM; i++) send_random_op();
    idle_cycles(1);
    drain_all();

    // both registers fill while the output is held off
    hold_ready_low <= 1'b1;
    repeat (2) @(negedge clk);
    op.fu    = `FPU_FU_FCMP;
    op.subop = `FCMP_FMIN;
    send_op(op, 32'h8000_0000, 32'h0000_0000, 16'h1111);
    op.fu    = `FPU_FU_FPMV;
    op.subop = `FPMV_CLASS;
    send_op(op, 32'h7F80_0001, 32'h0000_0000, 16'h2222);
    idle_cycles(10);
    hold_ready_low <= 1'b0;
    drain_all();
    repeat (4) @(negedge clk);

    if (errors == 0 && both_held != 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      if (both_held == 0) $display("both units never held a result at the same time");
      $display("TESTS FAILED");
      $fatal(1, "run ended with errors");
    end
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+source
source/fpu_pkg.sv
source/fpu_dispatch.sv
source/fcmp_unit.sv
source/fpmv_unit.sv
source/fpu_result_arbiter.sv
source/scalar_fpu.sv
dv/scalar_fpu_sva.sv
dv/tb_scalar_fpu.sv

// File: Bender.yml
package:
  name: scalar_fpu

sources:
  - include_dirs:
      - source
    files:
      - source/fpu_pkg.sv
      - source/fpu_dispatch.sv
      - source/fcmp_unit.sv
      - source/fpmv_unit.sv
      - source/fpu_result_arbiter.sv
      - source/scalar_fpu.sv

  - target: simulation
    include_dirs:
      - source
    files:
      - dv/scalar_fpu_sva.sv
      - dv/tb_scalar_fpu.sv
